//--- Makefile
# Verilator build and run of the Householder QR input stage testbench
TOP := tb_hh_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -j 0 -Wno-fatal --top-module $(TOP) -f flist.f -Mdir obj_dir

# A failing check ends in $fatal, which gives a nonzero exit status
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- flist.f
hh_pkg.sv
sdp_ram.sv
hh_din_select.sv
hh_core.sv
tb_clkgen.sv
tb_hh_core.sv

//--- hh_core.sv
/* Householder QR input stage top level
   dmx0, dmx1 and rtri row memories feeding the operand selector */
module hh_core #(
    parameter int RAM_WORDS = hh_pkg::RAM_WORDS_DEF,
    parameter int ADDR_W    = hh_pkg::ADDR_W_DEF
) (
    input  logic                                                clk,
    input  logic                                                rst,
    input  logic [hh_pkg::CNT_W-1:0]                            hh_cnt,
    input  logic                                                hh_st,
    input  logic [2*RAM_WORDS*hh_pkg::WORD_W-1:0]               hh_dout,

    // dmx0 column memory
    input  logic                                                dmx0_ena,
    input  logic [RAM_WORDS*hh_pkg::WORD_W/hh_pkg::BYTE_W-1:0]  dmx0_wea,
    input  logic [ADDR_W-1:0]                                   dmx0_addra,
    input  logic [RAM_WORDS*hh_pkg::WORD_W-1:0]                 dmx0_dina,
    input  logic                                                dmx0_enb,
    input  logic [ADDR_W-1:0]                                   dmx0_addrb,

    // dmx1 column memory
    input  logic                                                dmx1_ena,
    input  logic [RAM_WORDS*hh_pkg::WORD_W/hh_pkg::BYTE_W-1:0]  dmx1_wea,
    input  logic [ADDR_W-1:0]                                   dmx1_addra,
    input  logic [RAM_WORDS*hh_pkg::WORD_W-1:0]                 dmx1_dina,
    input  logic                                                dmx1_enb,
    input  logic [ADDR_W-1:0]                                   dmx1_addrb,

    // rtri triangular-factor memory
    input  logic                                                rtri_ena,
    input  logic [RAM_WORDS*hh_pkg::WORD_W/hh_pkg::BYTE_W-1:0]  rtri_wea,
    input  logic [ADDR_W-1:0]                                   rtri_addra,
    input  logic [RAM_WORDS*hh_pkg::WORD_W-1:0]                 rtri_dina,
    input  logic                                                rtri_enb,
    input  logic [ADDR_W-1:0]                                   rtri_addrb,

    output logic [RAM_WORDS*hh_pkg::WORD_W-1:0]                 dmx0_doutb,
    output logic [RAM_WORDS*hh_pkg::WORD_W-1:0]                 dmx1_doutb,
    output logic [RAM_WORDS*hh_pkg::WORD_W-1:0]                 rtri_doutb,
    output logic [2*RAM_WORDS*hh_pkg::WORD_W-1:0]               hh_din
);

    logic dmx0_rd;
    logic dmx1_rd;

    // An operand needs a dmx row and an rtri row in the same cycle
    assign dmx0_rd = dmx0_enb & rtri_enb;
    assign dmx1_rd = dmx1_enb & rtri_enb;

    // ----------------------------------------------------------
    // Row memories
    // ----------------------------------------------------------
    sdp_ram #(
        .RAM_WORDS (RAM_WORDS),
        .ADDR_W    (ADDR_W)
    ) u_dmx0 (
        .clk   (clk),
        .ena   (dmx0_ena),
        .wea   (dmx0_wea),
        .addra (dmx0_addra),
        .dina  (dmx0_dina),
        .enb   (dmx0_enb),
        .addrb (dmx0_addrb),
        .doutb (dmx0_doutb)
    );

    sdp_ram #(
        .RAM_WORDS (RAM_WORDS),
        .ADDR_W    (ADDR_W)
    ) u_dmx1 (
        .clk   (clk),
        .ena   (dmx1_ena),
        .wea   (dmx1_wea),
        .addra (dmx1_addra),
        .dina  (dmx1_dina),
        .enb   (dmx1_enb),
        .addrb (dmx1_addrb),
        .doutb (dmx1_doutb)
    );

    sdp_ram #(
        .RAM_WORDS (RAM_WORDS),
        .ADDR_W    (ADDR_W)
    ) u_rtri (
        .clk   (clk),
        .ena   (rtri_ena),
        .wea   (rtri_wea),
        .addra (rtri_addra),
        .dina  (rtri_dina),
        .enb   (rtri_enb),
        .addrb (rtri_addrb),
        .doutb (rtri_doutb)
    );

    // ----------------------------------------------------------
    // Operand selector
    // ----------------------------------------------------------
    hh_din_select #(
        .RAM_WORDS (RAM_WORDS)
    ) u_din_select (
        .clk      (clk),
        .rst      (rst),
        .hh_cnt   (hh_cnt),
        .dmx0_rd  (dmx0_rd),
        .dmx1_rd  (dmx1_rd),
        .dmx0_row (dmx0_doutb),
        .dmx1_row (dmx1_doutb),
        .rtri_row (rtri_doutb),
        .hh_st    (hh_st),
        .hh_dout  (hh_dout),
        .hh_din   (hh_din)
    );

endmodule

//--- hh_din_select.sv
/* Datapath operand builder: rtri/dmx row pairing, top-word masking by step,
   hh_dout feedback select and hold register */
module hh_din_select #(
    parameter int RAM_WORDS = hh_pkg::RAM_WORDS_DEF
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [hh_pkg::CNT_W-1:0]              hh_cnt,
    input  logic                                  dmx0_rd,
    input  logic                                  dmx1_rd,
    input  logic [RAM_WORDS*hh_pkg::WORD_W-1:0]   dmx0_row,
    input  logic [RAM_WORDS*hh_pkg::WORD_W-1:0]   dmx1_row,
    input  logic [RAM_WORDS*hh_pkg::WORD_W-1:0]   rtri_row,
    input  logic                                  hh_st,
    input  logic [2*RAM_WORDS*hh_pkg::WORD_W-1:0] hh_dout,
    output logic [2*RAM_WORDS*hh_pkg::WORD_W-1:0] hh_din
);

    localparam int ROW_W   = RAM_WORDS * hh_pkg::WORD_W;
    localparam int OP_W    = 2 * ROW_W;
    localparam int OP_WRDS = 2 * RAM_WORDS;

    // Operand seen as two rows or as a flat word array
    typedef union packed {
        struct packed {
            logic [ROW_W-1:0] rtri;     // Upper half
            logic [ROW_W-1:0] dmx;      // Lower half
        } half;
        logic [OP_WRDS-1:0][hh_pkg::WORD_W-1:0] word;
    } hh_word_u;

    // Clears the top cnt words, whole operand once cnt reaches a row
    function automatic hh_word_u mask_top(
        input hh_word_u                 src,
        input logic [hh_pkg::CNT_W-1:0] cnt
    );
        hh_word_u res;
        res = src;
        if (cnt >= RAM_WORDS) begin
            res = '0;
        end else begin
            for (int i = 0; i < RAM_WORDS; i++) begin
                if (i < cnt) begin
                    res.word[OP_WRDS-1-i] = '0;
                end
            end
        end
        return res;
    endfunction

    logic     dmx0_rd_q;
    logic     dmx1_rd_q;
    logic     rd_valid;
    hh_word_u rd_word;
    hh_word_u st_word;
    hh_word_u rd_masked;
    hh_word_u st_masked;
    logic [OP_W-1:0] din_hold;

    // ----------------------------------------------------------
    // Read conditions aligned to the memory read latency
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            dmx0_rd_q <= 1'b0;
            dmx1_rd_q <= 1'b0;
        end else begin
            dmx0_rd_q <= dmx0_rd;
            dmx1_rd_q <= dmx1_rd;
        end
    end

    assign rd_valid = dmx0_rd_q | dmx1_rd_q;

    // ----------------------------------------------------------
    // Operand build
    // ----------------------------------------------------------
    always_comb begin
        rd_word.half.rtri = rtri_row;
        // dmx0 wins when both columns were read together
        if (dmx0_rd_q) begin
            rd_word.half.dmx = dmx0_row;
        end else begin
            rd_word.half.dmx = dmx1_row;
        end
    end

    assign st_word   = hh_dout;         // Feedback from the datapath
    assign rd_masked = mask_top(rd_word, hh_cnt);
    assign st_masked = mask_top(st_word, hh_cnt);

    // Source priority: memory read, then feedback, then hold
    always_comb begin
        if (rd_valid) begin
            hh_din = rd_masked;
        end else if (hh_st) begin
            hh_din = st_masked;
        end else begin
            hh_din = din_hold;
        end
    end

    // ----------------------------------------------------------
    // Hold register
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            din_hold <= '0;
        end else begin
            din_hold <= hh_din;
        end
    end

endmodule

//--- hh_pkg.sv
/* Shared sizes of the Householder QR input stage
   word, byte-enable and step-count widths, default memory geometry */
package hh_pkg;

    // ----------------------------------------------------------
    // Element and write-enable granularity
    // ----------------------------------------------------------
    localparam int WORD_W = 32;         // One matrix element
    localparam int BYTE_W = 8;          // One bit of wea per byte

    // Reflection step index hh_cnt
    localparam int CNT_W = 8;

    // ----------------------------------------------------------
    // Default memory geometry
    // ----------------------------------------------------------
    // Words per row, so a row is RAM_WORDS_DEF * WORD_W bits
    localparam int RAM_WORDS_DEF = 4;

    // 64 rows per memory
    localparam int ADDR_W_DEF = 6;

endpackage

//--- sdp_ram.sv
/* Simple dual-port row memory
   byte-enabled write on port A, registered read on port B */
module sdp_ram #(
    parameter int RAM_WORDS = hh_pkg::RAM_WORDS_DEF,
    parameter int ADDR_W    = hh_pkg::ADDR_W_DEF
) (
    input  logic                                      clk,
    input  logic                                      ena,
    input  logic [RAM_WORDS*hh_pkg::WORD_W/hh_pkg::BYTE_W-1:0] wea,
    input  logic [ADDR_W-1:0]                         addra,
    input  logic [RAM_WORDS*hh_pkg::WORD_W-1:0]       dina,
    input  logic                                      enb,
    input  logic [ADDR_W-1:0]                         addrb,
    output logic [RAM_WORDS*hh_pkg::WORD_W-1:0]       doutb
);

    localparam int ROW_W = RAM_WORDS * hh_pkg::WORD_W;
    localparam int WE_W  = ROW_W / hh_pkg::BYTE_W;
    localparam int DEPTH = 2 ** ADDR_W;

    logic [ROW_W-1:0] mem [0:DEPTH-1];
    logic [ROW_W-1:0] rd_q = '0;          // Powers up cleared

    // ----------------------------------------------------------
    // Port A write
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (ena) begin
            for (int b = 0; b < WE_W; b++) begin
                if (wea[b]) begin
                    mem[addra][b*hh_pkg::BYTE_W +: hh_pkg::BYTE_W] <=
                        dina[b*hh_pkg::BYTE_W +: hh_pkg::BYTE_W];
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Port B read
    // ----------------------------------------------------------
    // Same-address collision returns the old row
    always_ff @(posedge clk) begin
        if (enb) begin
            rd_q <= mem[addrb];
        end
    end

    assign doutb = rd_q;    // Holds while enb is low

endmodule

//--- tb_clkgen.sv
/* Testbench clock source, period 4 */
module tb_clkgen #(
    parameter int HALF_PERIOD = 2
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

//--- tb_hh_core.sv
/* Directed testbench for the Householder QR input stage
   memory read/write, operand masking, source priority, feedback and hold */
module tb_hh_core;

    localparam int RAM_WORDS  = hh_pkg::RAM_WORDS_DEF;
    localparam int ADDR_W     = hh_pkg::ADDR_W_DEF;
    localparam int WORD_W     = hh_pkg::WORD_W;
    localparam int BYTE_W     = hh_pkg::BYTE_W;
    localparam int CNT_W      = hh_pkg::CNT_W;
    localparam int ROW_W      = RAM_WORDS * WORD_W;
    localparam int WE_W       = ROW_W / BYTE_W;
    localparam int OP_W       = 2 * ROW_W;
    localparam int N_ADDR     = 8;      // Rows exercised per memory
    localparam int MAX_CYCLES = 2000;   // Tests need roughly 150 cycles

    localparam int MEM_DMX0 = 0;
    localparam int MEM_DMX1 = 1;
    localparam int MEM_RTRI = 2;

    logic              clk;
    logic              rst;
    logic [CNT_W-1:0]  hh_cnt;
    logic              hh_st;
    logic [OP_W-1:0]   hh_dout;
    logic [OP_W-1:0]   hh_din;

    logic              dmx0_ena;
    logic [WE_W-1:0]   dmx0_wea;
    logic [ADDR_W-1:0] dmx0_addra;
    logic [ROW_W-1:0]  dmx0_dina;
    logic              dmx0_enb;
    logic [ADDR_W-1:0] dmx0_addrb;
    logic [ROW_W-1:0]  dmx0_doutb;

    logic              dmx1_ena;
    logic [WE_W-1:0]   dmx1_wea;
    logic [ADDR_W-1:0] dmx1_addra;
    logic [ROW_W-1:0]  dmx1_dina;
    logic              dmx1_enb;
    logic [ADDR_W-1:0] dmx1_addrb;
    logic [ROW_W-1:0]  dmx1_doutb;

    logic              rtri_ena;
    logic [WE_W-1:0]   rtri_wea;
    logic [ADDR_W-1:0] rtri_addra;
    logic [ROW_W-1:0]  rtri_dina;
    logic              rtri_enb;
    logic [ADDR_W-1:0] rtri_addrb;
    logic [ROW_W-1:0]  rtri_doutb;

    // Expected memory contents, indexed by memory then row
    logic [ROW_W-1:0] model [0:2][0:N_ADDR-1];

    logic [31:0] lcg_state = 32'hdd459955;
    int          cycle_count = 0;

    tb_clkgen u_clkgen (
        .clk (clk)
    );

    hh_core #(
        .RAM_WORDS (RAM_WORDS),
        .ADDR_W    (ADDR_W)
    ) hh_core_inst (
        .clk        (clk),
        .rst        (rst),
        .hh_cnt     (hh_cnt),
        .hh_st      (hh_st),
        .hh_dout    (hh_dout),
        .dmx0_ena   (dmx0_ena),
        .dmx0_wea   (dmx0_wea),
        .dmx0_addra (dmx0_addra),
        .dmx0_dina  (dmx0_dina),
        .dmx0_enb   (dmx0_enb),
        .dmx0_addrb (dmx0_addrb),
        .dmx1_ena   (dmx1_ena),
        .dmx1_wea   (dmx1_wea),
        .dmx1_addra (dmx1_addra),
        .dmx1_dina  (dmx1_dina),
        .dmx1_enb   (dmx1_enb),
        .dmx1_addrb (dmx1_addrb),
        .rtri_ena   (rtri_ena),
        .rtri_wea   (rtri_wea),
        .rtri_addra (rtri_addra),
        .rtri_dina  (rtri_dina),
        .rtri_enb   (rtri_enb),
        .rtri_addrb (rtri_addrb),
        .dmx0_doutb (dmx0_doutb),
        .dmx1_doutb (dmx1_doutb),
        .rtri_doutb (rtri_doutb),
        .hh_din     (hh_din)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("SIMULATION FAILED");
            $fatal(1, "Run did not finish within %0d clock cycles", MAX_CYCLES);
        end
    end

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    function automatic logic [31:0] rand32();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [ROW_W-1:0] rand_row();
        logic [ROW_W-1:0] row;
        for (int i = 0; i < RAM_WORDS; i++) begin
            row[i*WORD_W +: WORD_W] = rand32();
        end
        return row;
    endfunction

    function automatic logic [OP_W-1:0] rand_op();
        return {rand_row(), rand_row()};
    endfunction

    function automatic logic [ROW_W-1:0] merge_bytes(
        input logic [ROW_W-1:0] old_row,
        input logic [ROW_W-1:0] new_row,
        input logic [WE_W-1:0]  we
    );
        logic [ROW_W-1:0] res;
        res = old_row;
        for (int b = 0; b < WE_W; b++) begin
            if (we[b]) begin
                res[b*BYTE_W +: BYTE_W] = new_row[b*BYTE_W +: BYTE_W];
            end
        end
        return res;
    endfunction

    // Upper row with its top cnt words cleared, lower row untouched
    function automatic logic [OP_W-1:0] expect_operand(
        input logic [ROW_W-1:0] upper,
        input logic [ROW_W-1:0] lower,
        input int               cnt
    );
        logic [ROW_W-1:0] keep;
        if (cnt >= RAM_WORDS) begin
            return '0;
        end
        keep = {ROW_W{1'b1}} >> (cnt * WORD_W);
        return {upper & keep, lower};
    endfunction

    task automatic check_value(
        input string           name,
        input logic [OP_W-1:0] got,
        input logic [OP_W-1:0] exp
    );
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_idle();
        dmx0_ena = 1'b0;
        dmx1_ena = 1'b0;
        rtri_ena = 1'b0;
        dmx0_enb = 1'b0;
        dmx1_enb = 1'b0;
        rtri_enb = 1'b0;
    endtask

    // Row lands in memory at the following edge
    task automatic write_row(
        input int               mem,
        input int               addr,
        input logic [ROW_W-1:0] row,
        input logic [WE_W-1:0]  we
    );
        next_cycle();
        drive_idle();
        case (mem)
            MEM_DMX0: begin
                dmx0_ena   = 1'b1;
                dmx0_wea   = we;
                dmx0_addra = ADDR_W'(addr);
                dmx0_dina  = row;
            end
            MEM_DMX1: begin
                dmx1_ena   = 1'b1;
                dmx1_wea   = we;
                dmx1_addra = ADDR_W'(addr);
                dmx1_dina  = row;
            end
            default: begin
                rtri_ena   = 1'b1;
                rtri_wea   = we;
                rtri_addra = ADDR_W'(addr);
                rtri_dina  = row;
            end
        endcase
        model[mem][addr] = merge_bytes(model[mem][addr], row, we);
    endtask

    task automatic issue_read(
        input logic d0,
        input logic d1,
        input logic rt,
        input int   addr,
        input int   cnt
    );
        next_cycle();
        drive_idle();
        dmx0_enb   = d0;
        dmx1_enb   = d1;
        rtri_enb   = rt;
        dmx0_addrb = ADDR_W'(addr);
        dmx1_addrb = ADDR_W'(addr);
        rtri_addrb = ADDR_W'(addr);
        hh_cnt     = CNT_W'(cnt);
    endtask

    // Returns in the cycle after the read edge, ready to check
    task automatic read_rows(
        input logic d0,
        input logic d1,
        input logic rt,
        input int   addr,
        input int   cnt
    );
        issue_read(d0, d1, rt, addr, cnt);
        next_cycle();
        drive_idle();
        #1;
    endtask

    task automatic drive_feedback(input logic [OP_W-1:0] value, input int cnt);
        next_cycle();
        drive_idle();
        hh_st   = 1'b1;
        hh_dout = value;
        hh_cnt  = CNT_W'(cnt);
        #1;
    endtask

    // ----------------------------------------------------------
    // Tests
    // ----------------------------------------------------------
    task automatic test_reset();
        #1;
        check_value("hh_din", hh_din, '0);
    endtask

    task automatic test_mem_rw();
        logic [ROW_W-1:0] row;
        logic [WE_W-1:0]  we;
        for (int m = 0; m < 3; m++) begin
            for (int a = 0; a < N_ADDR; a++) begin
                write_row(m, a, rand_row(), '1);    // Known base row
                row = rand_row();
                we  = WE_W'(rand32());
                write_row(m, a, row, we);
                read_rows(m == MEM_DMX0, m == MEM_DMX1, m == MEM_RTRI, a, 0);
                case (m)
                    MEM_DMX0: check_value("dmx0_doutb", OP_W'(dmx0_doutb), OP_W'(model[m][a]));
                    MEM_DMX1: check_value("dmx1_doutb", OP_W'(dmx1_doutb), OP_W'(model[m][a]));
                    default:  check_value("rtri_doutb", OP_W'(rtri_doutb), OP_W'(model[m][a]));
                endcase
            end
        end
    endtask

    task automatic test_operand_mask();
        logic [OP_W-1:0] exp_op;
        int              cnt;
        int              a;
        for (int i = 0; i <= RAM_WORDS + 1; i++) begin
            cnt = (i > RAM_WORDS) ? 200 : i;
            a   = i % N_ADDR;
            read_rows(1'b1, 1'b0, 1'b1, a, cnt);
            exp_op = expect_operand(model[MEM_RTRI][a], model[MEM_DMX0][a], cnt);
            check_value("hh_din", hh_din, exp_op);
            next_cycle();
            #1;
            check_value("hh_din", hh_din, exp_op);  // Held after the read
        end
    endtask

    task automatic test_priority();
        logic [OP_W-1:0] exp_op;
        read_rows(1'b0, 1'b1, 1'b1, 2, 1);
        exp_op = expect_operand(model[MEM_RTRI][2], model[MEM_DMX1][2], 1);
        check_value("hh_din", hh_din, exp_op);

        // Both columns with rtri, dmx0 takes the lower half
        read_rows(1'b1, 1'b1, 1'b1, 3, 2);
        exp_op = expect_operand(model[MEM_RTRI][3], model[MEM_DMX0][3], 2);
        check_value("hh_din", hh_din, exp_op);
        check_value("dmx1_doutb", OP_W'(dmx1_doutb), OP_W'(model[MEM_DMX1][3]));

        // Column reads without rtri
        read_rows(1'b1, 1'b0, 1'b0, 5, 0);
        check_value("dmx0_doutb", OP_W'(dmx0_doutb), OP_W'(model[MEM_DMX0][5]));
        check_value("hh_din", hh_din, exp_op);
        read_rows(1'b0, 1'b1, 1'b0, 6, 0);
        check_value("dmx1_doutb", OP_W'(dmx1_doutb), OP_W'(model[MEM_DMX1][6]));
        check_value("hh_din", hh_din, exp_op);
    endtask

    task automatic test_feedback();
        logic [OP_W-1:0] fb;
        logic [OP_W-1:0] exp_op;
        for (int c = 0; c <= RAM_WORDS; c++) begin
            fb = rand_op();
            drive_feedback(fb, c);
            check_value("hh_din", hh_din, expect_operand(fb[OP_W-1:ROW_W], fb[ROW_W-1:0], c));
        end

        // Registered read beats hh_st in the same cycle
        issue_read(1'b1, 1'b0, 1'b1, 4, 1);
        next_cycle();
        drive_idle();
        hh_st   = 1'b1;
        hh_dout = rand_op();
        #1;
        exp_op = expect_operand(model[MEM_RTRI][4], model[MEM_DMX0][4], 1);
        check_value("hh_din", hh_din, exp_op);

        fb = rand_op();
        drive_feedback(fb, 2);
        exp_op = expect_operand(fb[OP_W-1:ROW_W], fb[ROW_W-1:0], 2);
        check_value("hh_din", hh_din, exp_op);

        // hh_st drops, operand stays
        next_cycle();
        hh_st   = 1'b0;
        hh_cnt  = '0;
        hh_dout = rand_op();
        #1;
        check_value("hh_din", hh_din, exp_op);
        next_cycle();
        #1;
        check_value("hh_din", hh_din, exp_op);
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        rst        = 1'b1;
        hh_cnt     = '0;
        hh_st      = 1'b0;
        hh_dout    = '0;
        dmx0_wea   = '0;
        dmx0_addra = '0;
        dmx0_dina  = '0;
        dmx0_addrb = '0;
        dmx1_wea   = '0;
        dmx1_addra = '0;
        dmx1_dina  = '0;
        dmx1_addrb = '0;
        rtri_wea   = '0;
        rtri_addra = '0;
        rtri_dina  = '0;
        rtri_addrb = '0;
        drive_idle();

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset();
        test_mem_rw();
        test_operand_mask();
        test_priority();
        test_feedback();

        next_cycle();
        drive_idle();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
